//--- Bender.yml
package:
  name: boothMultiplier

sources:
  - files:
      - hw/multPkg.sv
      - hw/boothPpGen.sv
      - hw/wallaceTree.sv
      - hw/carrySelectAdder.sv
      - hw/creditFifo.sv
      - hw/boothMultiplier.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tbBoothMult.sv

//--- include/tbTasks.svh
/*
  Driver, receiver model, compare tasks and directed tests
  for the Booth multiplier testbench.
*/
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [31:0] lcgNext();
  lcgState = lcgState * 32'd1103515245 + 32'd12345;
  return lcgState;
endfunction

task automatic checkProduct(string name, product_t got, product_t exp);
  if (got !== exp) begin
    $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    abortRun();
  end
endtask

task automatic checkBit(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    abortRun();
  end
endtask

task automatic checkCount(string name, int got, int exp);
  if (got != exp) begin
    $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    abortRun();
  end
endtask

// drive inputs on the falling edge and sample the registered outputs
task automatic nextCycle();
  @(negedge clk);
  cycleCount++;
  inValid = 1'b0;
  outCredit = returnNext;
  returnNext = 1'b0;
  if (inCredit) begin
    creditPulses++;
    upCredits++;
  end
  if (outValid) begin
    if (expQ.size() == 0) begin
      $display("outValid was raised with no product outstanding");
      abortRun();
    end
    checkProduct("outProduct", outProduct, expQ.pop_front());
    transfers++;
    lastOutCycle = cycleCount;
    // receiver frees the slot one cycle after the transfer
    returnNext = autoReturn;
  end
endtask

task automatic sendOp(operand_t a, operand_t b);
  nextCycle();
  while (upCredits == 0) begin
    nextCycle();
  end
  inValid = 1'b1;
  inA = a;
  inB = b;
  upCredits--;
  acceptCycle = cycleCount;
  expQ.push_back(product_t'(a) * product_t'(b));
endtask

// drain the queue, then one cycle for the last credit pulse
task automatic waitIdle();
  nextCycle();
  while (expQ.size() != 0) begin
    nextCycle();
  end
  nextCycle();
endtask

task automatic runResetTest();
  repeat (10) begin
    nextCycle();
    checkBit("outValid", outValid, 1'b0);
    checkBit("inCredit", inCredit, 1'b0);
  end
endtask

task automatic runCornerTest();
  operand_t aVals [6] = '{7'd0, 7'd127, 7'd127, 7'd1, 7'd64, 7'd85};
  operand_t bVals [6] = '{7'd0, 7'd127, 7'd1, 7'd127, 7'd85, 7'd42};
  autoReturn = 1'b1;
  for (int i = 0; i < 6; i++) begin
    sendOp(aVals[i], bVals[i]);
    while (expQ.size() != 0) begin
      nextCycle();
    end
    // outValid three cycles after the accepting edge on an idle pipeline
    checkCount("latency", lastOutCycle - acceptCycle, 3);
    waitIdle();
  end
endtask

task automatic runRandomTest();
  logic [31:0] r;
  operand_t a;
  operand_t b;
  autoReturn = 1'b1;
  for (int i = 0; i < 200; i++) begin
    r = lcgNext();
    a = r[22:16];
    r = lcgNext();
    b = r[22:16];
    sendOp(a, b);
  end
  waitIdle();
endtask

task automatic runBackPressureTest();
  int base;
  base = transfers;
  autoReturn = 1'b0;
  for (int i = 0; i < 4; i++) begin
    sendOp(operand_t'(i * 29 + 3), operand_t'(127 - i * 11));
  end
  while (transfers - base < 2) begin
    nextCycle();
  end
  // receiver credits used up
  repeat (20) begin
    nextCycle();
    checkBit("outValid", outValid, 1'b0);
  end
  repeat (4) begin
    returnNext = 1'b1;
    repeat (3) nextCycle();
  end
  checkCount("back-pressure transfers", transfers - base, 4);
  autoReturn = 1'b1;
  waitIdle();
endtask

task automatic checkAccounting();
  checkCount("inCredit pulses", creditPulses, transfers);
  checkCount("upstream credits", upCredits, FifoDepth);
endtask

`endif

//--- dv/tbBoothMult.sv
/*
  Testbench for the pipelined Booth multiplier.
  Drives operands under upstream credit control, models the receiver
  and checks every product, the latency and the credit accounting.
*/
module tbBoothMult
  import multPkg::*;
;

  localparam int FifoDepth = 4;
  localparam int OutCredits = 2;
  localparam int ClkPeriod = 8;
  // corner pairs, random stream, back-pressure burst
  localparam int TotalOps = 6 + 200 + 4;
  localparam int TimeoutCycles = TotalOps * 20 + 500;

  logic clk;
  logic rst;
  logic inValid;
  operand_t inA;
  operand_t inB;
  logic inCredit;
  logic outValid;
  product_t outProduct;
  logic outCredit;

  // testbench state shared by the tasks
  int upCredits;
  product_t expQ [$];
  int transfers;
  int creditPulses;
  int cycleCount;
  int acceptCycle;
  int lastOutCycle;
  logic autoReturn;
  logic returnNext;
  logic [31:0] lcgState;

  boothMultiplier #(
    .FifoDepth (FifoDepth),
    .OutCredits(OutCredits)
  ) u_boothMultiplier (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inA       (inA),
    .inB       (inB),
    .inCredit  (inCredit),
    .outValid  (outValid),
    .outProduct(outProduct),
    .outCredit (outCredit)
  );

  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  `include "tbTasks.svh"

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("watchdog: run did not finish within %0d clock cycles", TimeoutCycles);
    abortRun();
  end

  initial begin
    rst = 1'b1;
    inValid = 1'b0;
    inA = '0;
    inB = '0;
    outCredit = 1'b0;
    upCredits = FifoDepth;
    transfers = 0;
    creditPulses = 0;
    cycleCount = 0;
    acceptCycle = 0;
    lastOutCycle = 0;
    autoReturn = 1'b1;
    returnNext = 1'b0;
    lcgState = 32'd23242;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    runResetTest();
    runCornerTest();
    runRandomTest();
    runBackPressureTest();
    checkAccounting();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- hw/boothMultiplier.sv
/*
  Pipelined 7x7 unsigned Booth multiplier with credit flow control.
  Operands are registered, reduced by the Booth tree into a second
  register stage, added, then buffered until the receiver has credit.
*/
module boothMultiplier
  import multPkg::*;
#(
  parameter int FifoDepth = 4,
  parameter int OutCredits = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     inValid,
  input  operand_t inA,
  input  operand_t inB,
  output logic     inCredit,
  output logic     outValid,
  output product_t outProduct,
  input  logic     outCredit
);

  logic s1Valid;
  operand_t s1A;
  operand_t s1B;
  ppArray_t ppRows;
  treeRow_t treeSum;
  treeRow_t treeCarry;
  logic s2Valid;
  treeRow_t s2Sum;
  treeRow_t s2Carry;
  treeRow_t finalSum;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
    end else begin
      s1Valid <= inValid;
      s2Valid <= s1Valid;
    end
  end

  // stage payload, loaded only with valid data
  always_ff @(posedge clk) begin
    if (inValid) begin
      s1A <= inA;
      s1B <= inB;
    end
    if (s1Valid) begin
      s2Sum <= treeSum;
      s2Carry <= treeCarry;
    end
  end

  boothPpGen u_boothPpGen (
    .multiplicand(s1A),
    .multiplier  (s1B),
    .ppRows      (ppRows)
  );

  wallaceTree u_wallaceTree (
    .ppRows  (ppRows),
    .sumRow  (treeSum),
    .carryRow(treeCarry)
  );

  carrySelectAdder u_carrySelectAdder (
    .a  (s2Sum),
    .b  (s2Carry),
    .sum(finalSum)
  );

  // bits above the product only hold the folded sign constants
  creditFifo #(
    .FifoDepth (FifoDepth),
    .OutCredits(OutCredits)
  ) u_creditFifo (
    .clk       (clk),
    .rst       (rst),
    .wrValid   (s2Valid),
    .wrData    (finalSum[ProductWidth-1:0]),
    .outValid  (outValid),
    .outProduct(outProduct),
    .outCredit (outCredit),
    .inCredit  (inCredit)
  );

endmodule

//--- hw/boothPpGen.sv
/*
  Radix-4 modified Booth partial product generator.
  Recodes the multiplier into four signed digits and builds the five
  partial product rows, with constant ones in place of sign extension.
*/
module boothPpGen
  import multPkg::*;
(
  input  operand_t multiplicand,
  input  operand_t multiplier,
  output ppArray_t ppRows
);

  localparam int Digits = PpRows - 1;
  // magnitude of up to twice the multiplicand, plus the inverted sign
  localparam int BodyWidth = OperandWidth + 2;

  // multiplier with a zero below bit 0 and a zero above the top bit
  logic [OperandWidth+1:0] bExt;
  logic [Digits-1:0] digitNeg;
  logic [Digits-1:0] digitOne;
  logic [Digits-1:0] digitTwo;
  logic [BodyWidth-1:0] body [Digits];

  assign bExt = {1'b0, multiplier, 1'b0};

  for (genvar i = 0; i < Digits; i++) begin : gDigit
    logic [2:0] triple;
    logic [OperandWidth:0] mag;

    // overlapping triples, one digit per two multiplier bits
    assign triple = bExt[2*i +: 3];
    assign digitNeg[i] = triple[2];
    assign digitOne[i] = triple[1] ^ triple[0];
    assign digitTwo[i] = (triple[2] ^ triple[1]) & ~digitOne[i];

    // one or two times the multiplicand, zero if neither
    assign mag = ({(OperandWidth + 1){digitOne[i]}} & {1'b0, multiplicand})
               | ({(OperandWidth + 1){digitTwo[i]}} & {multiplicand, 1'b0});

    // ones complement for negative digits, inverted sign on top
    assign body[i] = {~digitNeg[i], mag ^ {(OperandWidth + 1){digitNeg[i]}}};
  end

  always_comb begin
    ppRows = '0;

    for (int i = 0; i < Digits; i++) begin
      ppRows[i][2*i +: BodyWidth] = body[i];
    end

    // constant ones just above the body of all but the last digit
    for (int i = 0; i < Digits - 1; i++) begin
      ppRows[i][2*i + BodyWidth] = 1'b1;
    end

    // +1 of a negative digit goes into the low end of the next row
    for (int i = 1; i <= Digits; i++) begin
      ppRows[i][2*i - 2] = digitNeg[i-1];
    end

    // last constant sits with the final correction bit
    ppRows[Digits][2*Digits] = 1'b1;
  end

endmodule

//--- hw/carrySelectAdder.sv
/*
  Carry-select adder for the two tree rows.
  Blocks of growing width each ripple twice, once per carry-in value,
  and the carry from the block below picks the result.
*/
module carrySelectAdder
  import multPkg::*;
(
  input  treeRow_t a,
  input  treeRow_t b,
  output treeRow_t sum
);

  localparam int Blocks = 6;
  // block boundaries, widths 1, 1, 2, 3, 4 and the rest
  localparam int Bound [Blocks+1] = '{0, 1, 2, 4, 7, 11, TreeWidth};

  // carry into each block
  logic [Blocks-1:0] blockCarry;

  // returns {carry, sum}
  function automatic logic [1:0] fullAdd(logic x, logic y, logic ci);
    return {(x & y) | (ci & (x ^ y)), x ^ y ^ ci};
  endfunction

  // block 0 sees a constant zero, so its select folds away
  assign blockCarry[0] = 1'b0;

  for (genvar k = 0; k < Blocks; k++) begin : gBlock
    localparam int Lo = Bound[k];
    localparam int Width = Bound[k+1] - Bound[k];

    logic [Width:0] ripple0;
    logic [Width:0] ripple1;
    logic [Width-1:0] sum0;
    logic [Width-1:0] sum1;

    always_comb begin
      ripple0[0] = 1'b0;
      ripple1[0] = 1'b1;
      for (int j = 0; j < Width; j++) begin
        {ripple0[j+1], sum0[j]} = fullAdd(a[Lo+j], b[Lo+j], ripple0[j]);
        {ripple1[j+1], sum1[j]} = fullAdd(a[Lo+j], b[Lo+j], ripple1[j]);
      end
    end

    assign sum[Lo +: Width] = blockCarry[k] ? sum1 : sum0;

    // top block carry is dropped
    if (k < Blocks - 1) begin : gCarry
      assign blockCarry[k+1] = blockCarry[k] ? ripple1[Width] : ripple0[Width];
    end
  end

endmodule

//--- hw/creditFifo.sv
/*
  Product buffer with credit flow control on both sides.
  Sends while it holds receiver credits and returns one sender
  credit per product that leaves.
*/
module creditFifo
  import multPkg::*;
#(
  parameter int FifoDepth = 4,
  parameter int OutCredits = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     wrValid,
  input  product_t wrData,
  output logic     outValid,
  output product_t outProduct,
  input  logic     outCredit,
  output logic     inCredit
);

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CountWidth = $clog2(FifoDepth + 1);
  localparam int CreditWidth = $clog2(OutCredits + 1);

  product_t mem [FifoDepth];
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth-1:0] wrPtr;
  logic [CountWidth-1:0] count;
  logic [CreditWidth-1:0] credits;

  function automatic logic [PtrWidth-1:0] nextPtr(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // every outValid cycle is a transfer
  assign outValid = (count != '0) && (credits != '0);
  assign outProduct = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrPtr] <= wrData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (wrValid) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (outValid) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({wrValid, outValid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CreditWidth'(OutCredits);
      inCredit <= 1'b0;
    end else begin
      case ({outCredit, outValid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
      // slot freed, hand a credit back upstream
      inCredit <= outValid;
    end
  end

endmodule

//--- hw/multPkg.sv
/*
  Shared widths and types for the pipelined 7x7 radix-4 Booth multiplier.
  Tree rows are aligned to column 0. They are wide enough for the
  sign extension constants and the final carry.
*/
package multPkg;

  // operand width fixes the Booth digit count and tree shape
  localparam int OperandWidth = 7;
  localparam int ProductWidth = 2 * OperandWidth;

  // four Booth digits plus the sign correction row
  localparam int PpRows = 5;

  // columns of the partial product matrix
  localparam int TreeWidth = 16;

  typedef logic [OperandWidth-1:0] operand_t;
  typedef logic [ProductWidth-1:0] product_t;

  typedef logic [TreeWidth-1:0] treeRow_t;

  // row i of the matrix starts at column 2i
  typedef treeRow_t [PpRows-1:0] ppArray_t;

endpackage

//--- hw/wallaceTree.sv
/*
  Wallace tree for the Booth partial product matrix.
  Three carry-save stages reduce five rows to one sum row
  and one carry row.
*/
module wallaceTree
  import multPkg::*;
(
  input  ppArray_t ppRows,
  output treeRow_t sumRow,
  output treeRow_t carryRow
);

  treeRow_t sum1;
  treeRow_t carry1;
  treeRow_t sum2;
  treeRow_t carry2;

  // 3:2 compression per column, carry moves up one column
  // columns with a zero input reduce to half adders after synthesis
  function automatic void csaRow(
    input  treeRow_t x,
    input  treeRow_t y,
    input  treeRow_t z,
    output treeRow_t s,
    output treeRow_t c
  );
    c = '0;
    for (int col = 0; col < TreeWidth; col++) begin
      s[col] = x[col] ^ y[col] ^ z[col];
      // carry out of the top column is beyond the product
      if (col < TreeWidth - 1) begin
        c[col+1] = (x[col] & y[col]) | (y[col] & z[col]) | (z[col] & x[col]);
      end
    end
  endfunction

  // stage 1, rows 0 to 2
  always_comb begin
    csaRow(ppRows[0], ppRows[1], ppRows[2], sum1, carry1);
  end

  // stage 2 folds in row 3
  always_comb begin
    csaRow(sum1, carry1, ppRows[3], sum2, carry2);
  end

  // stage 3 folds in the correction row
  always_comb begin
    csaRow(sum2, carry2, ppRows[4], sumRow, carryRow);
  end

endmodule

//--- project.f
+incdir+include
hw/multPkg.sv
hw/boothPpGen.sv
hw/wallaceTree.sv
hw/carrySelectAdder.sv
hw/creditFifo.sv
hw/boothMultiplier.sv
dv/tbBoothMult.sv
